// File: design/fpuPkg.sv
////////////////////
// single precision only, no NaN boxing and no rounding mode
////////////////////

package fpuPkg;

   ////////////////////
   // field widths
   ////////////////////
   localparam int FloatWidth  = 32;   // one binary32 value
   localparam int ExpWidth    = 8;
   localparam int FracWidth   = 23;
   localparam int RegAdrWidth = 5;    // f0..f31, f0 is a real register
   localparam int ClassWidth  = 10;   // fclass one-hot mask

   ////////////////////
   // RV32F encodings
   ////////////////////
   localparam logic [6:0] OpFp            = 7'b1010011; // OP-FP major opcode
   localparam logic [6:0] Funct7Sgnj      = 7'b0010000; // fsgnj/fsgnjn/fsgnjx
   localparam logic [6:0] Funct7Cmp       = 7'b1010000; // feq/flt/fle
   localparam logic [6:0] Funct7ClassMvXW = 7'b1110000; // fclass and fmv.x.w, split by funct3
   localparam logic [6:0] Funct7MvWX      = 7'b1111000; // fmv.w.x

   // operation carried down the pipe
   typedef enum logic [3:0] {
      opSgnj,
      opSgnjn,
      opSgnjx,
      opFeq,
      opFlt,
      opFle,
      opClass,
      opMvXW,
      opMvWX,
      opIllegal     // anything not listed above
   } fpOp_t;

   // execute operand source
   typedef enum logic {
      fwdNone,      // value read in decode
      fwdWriteback  // result sitting in writeback
   } fwdSel_t;

   typedef logic [FloatWidth-1:0]  flt_t;
   typedef logic [RegAdrWidth-1:0] regAdr_t;

endpackage

// File: design/fpuDecode.sv
////////////////////
// only the RV32F subset kept here decodes, the rest reports illegal
////////////////////

module fpuDecode import fpuPkg::*; (
   input  logic [31:0] instr,
   output fpOp_t       op,
   output regAdr_t     rs1,
   output regAdr_t     rs2,
   output regAdr_t     rd,
   output logic        fpWrite,   // result goes to an FP register
   output logic        intWrite   // result goes out on the integer channel
);

   logic [6:0] opcode;
   logic [6:0] funct7;
   logic [2:0] funct3;

   assign opcode = instr[6:0];
   assign funct7 = instr[31:25];
   assign funct3 = instr[14:12];

   // register fields, always extracted
   assign rs1 = instr[19:15];
   assign rs2 = instr[24:20];
   assign rd  = instr[11:7];

   always_comb begin
      op = opIllegal;   // default for every unknown encoding
      if (opcode == OpFp) begin
         case (funct7)
            Funct7Sgnj: begin
               case (funct3)
                  3'b000:  op = opSgnj;
                  3'b001:  op = opSgnjn;
                  3'b010:  op = opSgnjx;
                  default: op = opIllegal;
               endcase
            end
            Funct7Cmp: begin
               case (funct3)
                  3'b010:  op = opFeq;
                  3'b001:  op = opFlt;
                  3'b000:  op = opFle;
                  default: op = opIllegal;
               endcase
            end
            Funct7ClassMvXW: begin
               // rs2 field must be zero for both
               if (rs2 == '0 && funct3 == 3'b001) op = opClass;
               else if (rs2 == '0 && funct3 == 3'b000) op = opMvXW;
            end
            Funct7MvWX: begin
               if (rs2 == '0 && funct3 == 3'b000) op = opMvWX;
            end
            default: op = opIllegal;
         endcase
      end
   end

   // sign injection and fmv.w.x stay in the FP file
   assign fpWrite  = op inside {opSgnj, opSgnjn, opSgnjx, opMvWX};
   assign intWrite = ~fpWrite;  // compares, fclass, fmv.x.w and illegal report a beat

endmodule

// File: design/fpuRegFile.sv
////////////////////
// two read ports, one write port, write-through on same-cycle access
////////////////////

module fpuRegFile import fpuPkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  regAdr_t rdAdr1,
   input  regAdr_t rdAdr2,
   input  logic    wrEn,
   input  regAdr_t wrAdr,
   input  flt_t    wrData,
   output flt_t    rdData1,
   output flt_t    rdData2
);

   flt_t regs [2**RegAdrWidth];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 2**RegAdrWidth; i++) begin
            regs[i] <= '0;   // all registers start at +0
         end
      end else if (wrEn) begin
         regs[wrAdr] <= wrData;
      end
   end

   // writeback data bypasses the array when decode reads the same register
   assign rdData1 = (wrEn && wrAdr == rdAdr1) ? wrData : regs[rdAdr1];
   assign rdData2 = (wrEn && wrAdr == rdAdr2) ? wrData : regs[rdAdr2];

endmodule

// File: design/fpuForward.sv
////////////////////
// one forwarding source only, older results come through the file
////////////////////

module fpuForward import fpuPkg::*; (
   input  regAdr_t exRs1,
   input  regAdr_t exRs2,
   input  regAdr_t wbRd,
   input  logic    wbFpWrite,
   input  logic    wbValid,
   output fwdSel_t fwd1,
   output fwdSel_t fwd2
);

   logic wbHit;   // writeback holds a live FP write

   assign wbHit = wbValid & wbFpWrite;

   // a match on either source takes the writeback value
   assign fwd1 = (wbHit && exRs1 == wbRd) ? fwdWriteback : fwdNone;
   assign fwd2 = (wbHit && exRs2 == wbRd) ? fwdWriteback : fwdNone;

endmodule

// File: design/fpuExecute.sv
////////////////////
// single cycle datapath, invalid is only raised by compares
////////////////////

module fpuExecute import fpuPkg::*; (
   input  fpOp_t       op,
   input  flt_t        srcX,
   input  flt_t        srcY,
   input  logic [31:0] intSrc,   // integer operand for fmv.w.x
   output logic [31:0] result,
   output logic        invalid
);

   // {zero, subnormal, inf, quiet NaN, signaling NaN}
   function automatic logic [4:0] kindOf(flt_t v);
      logic [ExpWidth-1:0]  e;
      logic [FracWidth-1:0] f;
      logic                 expMax;
      logic                 expZero;
      e       = v[FloatWidth-2 -: ExpWidth];
      f       = v[FracWidth-1:0];
      expMax  = &e;
      expZero = ~|e;
      return {expZero & ~|f, expZero & |f, expMax & ~|f,
              expMax & f[FracWidth-1], expMax & |f & ~f[FracWidth-1]};
   endfunction

   ////////////////////
   // unpack
   ////////////////////
   logic xSign, ySign;
   logic xZero, xSub, xInf, xQNaN, xSNaN, xNorm;
   logic [4:0] yKind;
   logic yZero, yNaN, ySNaN;

   assign xSign = srcX[FloatWidth-1];
   assign ySign = srcY[FloatWidth-1];
   assign {xZero, xSub, xInf, xQNaN, xSNaN} = kindOf(srcX);
   assign xNorm = ~(xZero | xSub | xInf | xQNaN | xSNaN);

   assign yKind = kindOf(srcY);
   assign yZero = yKind[4];
   assign yNaN  = |yKind[1:0];
   assign ySNaN = yKind[0];

   ////////////////////
   // compare
   ////////////////////
   logic anyNaN, bothZero, magLt, magGt, eq, lt;

   assign anyNaN   = xQNaN | xSNaN | yNaN;
   assign bothZero = xZero & yZero;           // +0 and -0 are equal
   assign magLt    = srcX[FloatWidth-2:0] < srcY[FloatWidth-2:0];
   assign magGt    = srcX[FloatWidth-2:0] > srcY[FloatWidth-2:0];

   assign eq = ~anyNaN & ((srcX == srcY) | bothZero);
   // differing signs: negative one is smaller; both negative flips magnitude order
   assign lt = ~anyNaN & ~bothZero &
               ((xSign != ySign) ? xSign : (xSign ? magGt : magLt));

   // classify mask, bit 0 is -inf up to bit 9 quiet NaN
   logic [ClassWidth-1:0] classMask;
   assign classMask = {xQNaN, xSNaN,
                       ~xSign & xInf, ~xSign & xNorm, ~xSign & xSub, ~xSign & xZero,
                       xSign & xZero, xSign & xSub, xSign & xNorm, xSign & xInf};

   ////////////////////
   // result select
   ////////////////////
   always_comb begin
      result  = '0;     // illegal ops report zero
      invalid = 1'b0;
      case (op)
         opSgnj:  result = {ySign, srcX[FloatWidth-2:0]};          // magnitude kept
         opSgnjn: result = {~ySign, srcX[FloatWidth-2:0]};
         opSgnjx: result = {xSign ^ ySign, srcX[FloatWidth-2:0]};
         opFeq: begin
            result  = {{(FloatWidth-1){1'b0}}, eq};
            invalid = xSNaN | ySNaN;   // quiet NaN is fine for feq
         end
         opFlt: begin
            result  = {{(FloatWidth-1){1'b0}}, lt};
            invalid = anyNaN;
         end
         opFle: begin
            result  = {{(FloatWidth-1){1'b0}}, lt | eq};
            invalid = anyNaN;
         end
         opClass: result = {{(FloatWidth-ClassWidth){1'b0}}, classMask};
         opMvXW:  result = srcX;     // raw bits to integer side
         opMvWX:  result = intSrc;   // raw bits into FP file
         default: result = '0;
      endcase
   end

endmodule

// File: design/fpuTop.sv
////////////////////
// three stages, one op per cycle, outReady low holds the whole pipe
////////////////////

module fpuTop import fpuPkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        inValid,
   input  logic [31:0] inInstr,
   input  logic [31:0] inIntSrc,
   output logic        inReady,
   input  logic        outReady,
   output logic        outValid,
   output logic [31:0] outData,
   output logic        outInvalid,
   output logic        outIllegal
);

   logic stall;   // pending beat not taken

   // decode stage
   logic        decValid;
   logic [31:0] decInstr;
   logic [31:0] decIntSrc;
   fpOp_t       decOp;
   regAdr_t     decRs1, decRs2, decRd;
   logic        decFpWrite, decIntWrite;
   flt_t        decData1, decData2;

   // execute stage
   logic        exValid;
   fpOp_t       exOp;
   regAdr_t     exRs1, exRs2, exRd;
   logic        exFpWrite, exIntWrite;
   flt_t        exData1, exData2;
   logic [31:0] exIntSrc;
   fwdSel_t     fwd1, fwd2;
   flt_t        srcX, srcY;
   logic [31:0] exResult;
   logic        exInvalid;

   // writeback stage
   logic        wbValid;
   regAdr_t     wbRd;
   logic        wbFpWrite, wbIntWrite;
   flt_t        wbResult;
   logic        wbInvalid, wbIllegal;
   logic        rfWrEn;

   ////////////////////
   // stall rule
   ////////////////////
   assign stall   = outValid & ~outReady;
   assign inReady = ~stall;

   always_ff @(posedge clk) begin
      if (rst) begin
         decValid <= 1'b0;
         exValid  <= 1'b0;
         wbValid  <= 1'b0;
      end else if (!stall) begin
         decValid <= inValid;    // accepted when inReady is high
         exValid  <= decValid;
         wbValid  <= exValid;
      end
   end

   ////////////////////
   // decode
   ////////////////////
   always_ff @(posedge clk) begin
      if (!stall) begin
         decInstr  <= inInstr;
         decIntSrc <= inIntSrc;
      end
   end

   fpuDecode i_decode (.instr(decInstr), .op(decOp), .rs1(decRs1), .rs2(decRs2), .rd(decRd),
                       .fpWrite(decFpWrite), .intWrite(decIntWrite));

   assign rfWrEn = wbValid & wbFpWrite & ~stall;   // one write per writeback entry

   fpuRegFile i_regFile (.clk, .rst, .rdAdr1(decRs1), .rdAdr2(decRs2), .wrEn(rfWrEn),
                         .wrAdr(wbRd), .wrData(wbResult), .rdData1(decData1), .rdData2(decData2));

   ////////////////////
   // execute
   ////////////////////
   always_ff @(posedge clk) begin
      if (!stall) begin
         exOp       <= decOp;
         exRs1      <= decRs1;
         exRs2      <= decRs2;
         exRd       <= decRd;
         exFpWrite  <= decFpWrite;
         exIntWrite <= decIntWrite;
         exData1    <= decData1;
         exData2    <= decData2;
         exIntSrc   <= decIntSrc;
      end
   end

   fpuForward i_forward (.exRs1, .exRs2, .wbRd, .wbFpWrite, .wbValid, .fwd1, .fwd2);

   // previous instruction's result overrides the stale read
   assign srcX = (fwd1 == fwdWriteback) ? wbResult : exData1;
   assign srcY = (fwd2 == fwdWriteback) ? wbResult : exData2;

   fpuExecute i_execute (.op(exOp), .srcX, .srcY, .intSrc(exIntSrc), .result(exResult),
                         .invalid(exInvalid));

   ////////////////////
   // writeback
   ////////////////////
   always_ff @(posedge clk) begin
      if (!stall) begin
         wbRd       <= exRd;
         wbFpWrite  <= exFpWrite;
         wbIntWrite <= exIntWrite;
         wbResult   <= exResult;
         wbInvalid  <= exInvalid;
         wbIllegal  <= (exOp == opIllegal);
      end
   end

   // payload regs hold while stalled, so the beat stays steady
   assign outValid   = wbValid & wbIntWrite;
   assign outData    = wbResult;
   assign outInvalid = wbInvalid;
   assign outIllegal = wbIllegal;

endmodule

// File: tb/fpuTop_checker.sv
////////////////////
// bound into fpuTop, all checks sampled on the rising clock edge
////////////////////

module fpuTop_checker (
   input logic        clk,
   input logic        rst,
   input logic        inReady,
   input logic        outReady,
   input logic        outValid,
   input logic [31:0] outData,
   input logic        outInvalid,
   input logic        outIllegal
);
   timeunit 1ns;
   timeprecision 1ps;

   // a waiting beat stays valid and keeps its payload
   stableInStall: assert property (@(posedge clk) disable iff (rst)
         outValid && !outReady |=> outValid && $stable({outData, outInvalid, outIllegal}))
      else $error("output beat changed while outReady was low");

   readyRule: assert property (@(posedge clk) disable iff (rst)
         inReady == !(outValid && !outReady))   // stall is the only thing that drops inReady
      else $error("inReady does not follow outValid and outReady");

   resetClears: assert property (@(posedge clk) rst |=> !outValid)
      else $error("outValid high in the cycle after reset");

endmodule

// File: tb/fpuTb.sv
////////////////////
// golden table path tb/fpuGolden.txt is relative to the project root
////////////////////

module fpuTb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int MaxEntries = 64;                    // records the table can hold
   localparam int Cols       = 6;                     // words per record
   localparam int AdrWidth   = $clog2(MaxEntries * Cols);
   localparam logic [31:0] LfsrTaps = 32'h80200003;   // x^32 + x^22 + x^2 + x + 1

   logic        clk;
   logic        rst;
   logic        inValid;
   logic [31:0] inInstr;
   logic [31:0] inIntSrc;
   logic        inReady;
   logic        outReady;
   logic        outValid;
   logic [31:0] outData;
   logic        outInvalid;
   logic        outIllegal;

   logic [31:0] golden [MaxEntries*Cols];   // instr, intSrc, kind, data, invalid, illegal
   int          pending [$];                // records still owed a beat in order
   logic [31:0] lfsr;                       // back-pressure source
   int          numEntries;
   int          next;                       // record currently offered
   int          cycles;
   int          limit;
   int          valueErrors;
   int          otherErrors;
   logic        done;

   fpuTop i_dut (.clk, .rst, .inValid, .inInstr, .inIntSrc, .inReady, .outReady, .outValid,
                 .outData, .outInvalid, .outIllegal);

   bind fpuTop fpuTop_checker i_checker (.*);

   // one word of the golden table
   function automatic logic [31:0] goldenWord(input int rec, input int col);
      logic [AdrWidth-1:0] adr;
      adr = AdrWidth'(rec * Cols + col);
      return golden[adr];
   endfunction

   // one Galois step that drops the taken lsb
   function automatic logic [31:0] nextLfsr(input logic [31:0] s);
      return {1'b0, s[31:1]} ^ (s[0] ? LfsrTaps : 32'h0);
   endfunction

   task automatic checkData(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         valueErrors++;
         $display("** Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic checkFlag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         valueErrors++;
         $display("** Error %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   // oldest owed record against the beat on the bus
   task automatic takeBeat();
      int          rec;
      logic [31:0] expInvalid;
      logic [31:0] expIllegal;
      if (pending.size() == 0) begin
         otherErrors++;
         $display("output beat with data %h arrived but no instruction owes one", outData);
      end else begin
         rec        = pending.pop_front();
         expInvalid = goldenWord(rec, 4);
         expIllegal = goldenWord(rec, 5);
         checkData($sformatf("record %0d data", rec), goldenWord(rec, 3), outData);
         checkFlag($sformatf("record %0d invalid", rec), expInvalid[0], outInvalid);
         checkFlag($sformatf("record %0d illegal", rec), expIllegal[0], outIllegal);
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;   // 100 ns period
   end

   initial begin
      rst      <= 1'b1;
      inValid  <= 1'b0;
      inInstr  <= '0;
      inIntSrc <= '0;
      outReady <= 1'b0;
      lfsr        = 32'hf4ab;
      next        = 0;
      cycles      = 0;
      valueErrors = 0;
      otherErrors = 0;
      done        = 1'b0;
      $readmemh("tb/fpuGolden.txt", golden);
      numEntries = 0;
      while (numEntries < MaxEntries && goldenWord(numEntries, 2) != 32'hf) begin
         numEntries++;   // kind f closes the table
      end
      limit = 20 * numEntries + 50;

      repeat (2) @(posedge clk);
      rst <= 1'b0;

      ////////////////////
      // stream records under random outReady
      ////////////////////
      while (!done && cycles < limit) begin
         if (next < numEntries) begin
            inValid  <= 1'b1;                     // held until taken
            inInstr  <= goldenWord(next, 0);
            inIntSrc <= goldenWord(next, 1);
         end else begin
            inValid <= 1'b0;
         end
         outReady <= lfsr[0];
         lfsr = nextLfsr(lfsr);
         @(posedge clk);
         cycles++;
         if (inValid && inReady) begin
            if (goldenWord(next, 2) == 32'h1) pending.push_back(next);
            next++;
         end
         if (outValid && outReady) takeBeat();
         done = (next == numEntries) && (pending.size() == 0);
      end

      if (!done) begin
         otherErrors++;
         $display("timeout after %0d cycles with %0d of %0d records sent and %0d beats missing",
                  cycles, next, numEntries, pending.size());
      end else begin
         inValid  <= 1'b0;
         outReady <= 1'b1;
         repeat (4) begin   // pipe must stay quiet now
            @(posedge clk);
            if (outValid) begin
               otherErrors++;
               $display("extra output beat after the last expected one, data %h", outData);
            end
         end
      end

      $display("errors: %0d value, %0d other", valueErrors, otherErrors);
      if (valueErrors + otherErrors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: tb/fpuGolden.txt
// columns: instr, intSrc, kind, expected data, expected invalid, expected illegal (hex)
// kind 0 gives no beat, kind 1 one beat and kind f ends the list
F00000D3 3FC00000 0 00000000 0 0   // fmv.w.x f1 = 1.5
E0008053 00000000 1 3FC00000 0 0   // fmv.x.w f1 right behind its write
F0000153 C0200000 0 00000000 0 0   // f2 = -2.5
F00001D3 7FC00000 0 00000000 0 0   // f3 = quiet NaN
E0010053 00000000 1 C0200000 0 0   // fmv.x.w f2 two places back
F0000253 7F800001 0 00000000 0 0   // f4 = signaling NaN
F00002D3 80000000 0 00000000 0 0   // f5 = -0
20208353 00000000 0 00000000 0 0   // fsgnj f6, f1, f2
E0030053 00000000 1 BFC00000 0 0   // f6 = -1.5
202113D3 00000000 0 00000000 0 0   // fsgnjn f7, f2, f2
2023A453 00000000 0 00000000 0 0   // fsgnjx f8, f7, f2 with f7 forwarded
E0038053 00000000 1 40200000 0 0   // f7 = 2.5
E0040053 00000000 1 C0200000 0 0   // f8 = -2.5
A0111053 00000000 1 00000001 0 0   // flt f2, f1
A0611053 00000000 1 00000001 0 0   // flt f2, f6 both negative
A0502053 00000000 1 00000001 0 0   // feq +0, -0
A011A053 00000000 1 00000000 0 0   // feq qNaN quiet
A0119053 00000000 1 00000000 1 0   // flt qNaN
A0308053 00000000 1 00000000 1 0   // fle qNaN
A0422053 00000000 1 00000000 1 0   // feq sNaN
A0409053 00000000 1 00000000 1 0   // flt sNaN
A0120053 00000000 1 00000000 1 0   // fle sNaN
F00004D3 FF800000 0 00000000 0 0   // f9 = -inf
F0000553 807FFFFF 0 00000000 0 0   // f10 = negative subnormal
F00005D3 00000001 0 00000000 0 0   // f11 = positive subnormal
F0000653 7F800000 0 00000000 0 0   // f12 = +inf
E0061053 00000000 1 00000080 0 0   // fclass +inf
E0049053 00000000 1 00000001 0 0   // fclass -inf
E0011053 00000000 1 00000002 0 0   // fclass negative normal
E0051053 00000000 1 00000004 0 0   // fclass negative subnormal
E0029053 00000000 1 00000008 0 0   // fclass -0
E0001053 00000000 1 00000010 0 0   // fclass +0
E0059053 00000000 1 00000020 0 0   // fclass positive subnormal
E0009053 00000000 1 00000040 0 0   // fclass positive normal
E0021053 00000000 1 00000100 0 0   // fclass sNaN
E0019053 00000000 1 00000200 0 0   // fclass qNaN
00000000 00000000 1 00000000 0 1   // opcode zero
200030D3 00000000 1 00000000 0 1   // sign injection funct3 3 aimed at f1
E0008053 00000000 1 3FC00000 0 0   // f1 untouched
F0100153 12345678 1 00000000 0 1   // fmv.w.x with rs2 set aimed at f2
E0010053 00000000 1 C0200000 0 0   // f2 untouched
00000000 00000000 F 00000000 0 0   // end of list

// File: fpuLite.f
design/fpuPkg.sv
design/fpuDecode.sv
design/fpuRegFile.sv
design/fpuForward.sv
design/fpuExecute.sv
design/fpuTop.sv
tb/fpuTop_checker.sv
tb/fpuTb.sv

// File: runSim.sh
#!/bin/sh
# build the FPU testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/1ps --top-module fpuTb -f fpuLite.f -o fpuSim
result=$(./obj_dir/fpuSim)
echo "$result"
# fails the script unless the pass line is present
echo "$result" | grep -qx "Testbench passed"
